// ==== list.f ====
+incdir+rtl
+incdir+verification
rtl/render_pkg.sv
rtl/vga_timing.sv
rtl/scroll_offset.sv
rtl/scene_layers.sv
rtl/bird_sprite.sv
rtl/pixel_compositor.sv
rtl/game_display_top.sv
verification/tb_game_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pixel path testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_game_display -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== verification/tb_pixel_model.svh ====
// Reference model of the pixel path
// Scenery, pipe and bird colour rules, layer priority and pause dimming
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

`include "render_macros.svh"

// Scenery band by row, stripes counted from the scrolled column
function automatic rgb_t scenery_colour(input int x, input int y, input int hill_ofs,
	input int floor_ofs);
	int stripe;
	if (y < `HILL_Y) begin
		return `SKY_COLOUR;
	end
	if (y < `FLOOR_Y) begin
		stripe = ((x + hill_ofs) % `DISP_W) / 8;
		return (stripe % 2 == 0) ? `HILL_DARK : `HILL_LIGHT;
	end
	if (y < `FLOOR_Y + `FLOOR_H) begin
		stripe = ((x + floor_ofs) % `DISP_W) / 4;
		return (stripe % 2 == 0) ? `FLOOR_DARK : `FLOOR_LIGHT;
	end
	return `GROUND_COLOUR;
endfunction

// First pipe that covers the pixel, pipe 0 checked first
function automatic logic pipe_lookup(input int x, input int y,
	input logic [`NUM_PIPES*$bits(coord_t)-1:0] pxf,
	input logic [`NUM_PIPES*$bits(coord_t)-1:0] pyf, output rgb_t colour);
	int px;
	int py;
	colour = `PIPE_BODY;
	for (int i = 0; i < `NUM_PIPES; i++) begin
		px = int'(pxf[i*$bits(coord_t) +: $bits(coord_t)]);
		py = int'(pyf[i*$bits(coord_t) +: $bits(coord_t)]);
		if (x >= px && x < px + `PIPE_W && y < `FLOOR_Y &&
			(y < py - `PIPE_GAP / 2 || y >= py + `PIPE_GAP / 2)) begin
			colour = (x - px < 4 || x - px >= `PIPE_W - 4) ? `PIPE_EDGE : `PIPE_BODY;
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

// Bird box minus the four corner squares
function automatic logic bird_covers(input int x, input int y, input int bx, input int by);
	logic edge_col;
	logic edge_row;
	edge_col = (x - bx < `BIRD_CORNER) || (x - bx >= `BIRD_W - `BIRD_CORNER);
	edge_row = (y - by < `BIRD_CORNER) || (y - by >= `BIRD_H - `BIRD_CORNER);
	if (x < bx || x >= bx + `BIRD_W || y < by || y >= by + `BIRD_H) begin
		return 1'b0;
	end
	return !(edge_col && edge_row);
endfunction

function automatic rgb_t bird_shade(input int frame);
	case (frame)
		1:       return `BIRD_COLOUR_1;
		2:       return `BIRD_COLOUR_2;
		default: return `BIRD_COLOUR_0;
	endcase
endfunction

function automatic rgb_t dim_channels(input rgb_t c);
	return {c[23:16] >> 2, c[15:8] >> 2, c[7:0] >> 2};
endfunction

// Scenery moves on the title screen and in the game only
function automatic logic scroll_moves(input game_state_t st);
	return (st == start_screen) || (st == in_game);
endfunction

function automatic rgb_t expected_rgb(input game_state_t st, input int x, input int y,
	input int hill_ofs, input int floor_ofs, input int bx, input int by, input int frame,
	input logic [`NUM_PIPES*$bits(coord_t)-1:0] pxf,
	input logic [`NUM_PIPES*$bits(coord_t)-1:0] pyf);
	rgb_t front;
	rgb_t pipe_c;
	logic pipe_on;
	pipe_on = pipe_lookup(x, y, pxf, pyf, pipe_c);
	if (bird_covers(x, y, bx, by)) begin
		front = bird_shade(frame);
	end else if (pipe_on && st != start_screen) begin
		front = pipe_c;
	end else begin
		front = scenery_colour(x, y, hill_ofs, floor_ofs);
	end
	return (st == paused) ? dim_channels(front) : front;
endfunction

`endif

// ==== verification/tb_game_display.sv ====
// Testbench of the game display pixel path
// Clock, reset, frame stimulus, scan of the pixel stream and checks
`timescale 1ns/10ps
`include "render_macros.svh"

module tb_game_display
	import render_pkg::*;
;

	`include "tb_pixel_model.svh"

	localparam int TIMEOUT_CYCLES = 3 * `H_TOTAL * `V_TOTAL;

	logic                                 BG_clk;
	logic                                 rst;
	game_state_t                          game_state;
	bird_frame_t                          bird_frame;
	coord_t                               bird_x;
	coord_t                               bird_y;
	logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_x_flat;
	logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_y_flat;
	logic                                 hsync;
	logic                                 vsync;
	logic                                 de;
	rgb_t                                 rgb;

	// Scan state, owned by the monitor
	int   col;
	int   row;
	int   hs_low;
	int   hs_period;
	int   vs_low;
	int   frame_cycles;
	int   frames_started;
	int   visible_done;
	int   model_hill;
	int   model_floor;
	logic de_prev;
	logic hs_prev;
	logic vs_prev;
	logic hs_seen;
	logic vs_seen;
	rgb_t exp_rgb;

	game_display_top i_game_display_top (
		.BG_clk      (BG_clk),
		.rst         (rst),
		.game_state  (game_state),
		.bird_frame  (bird_frame),
		.bird_x      (bird_x),
		.bird_y      (bird_y),
		.pipe_x_flat (pipe_x_flat),
		.pipe_y_flat (pipe_y_flat),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.rgb         (rgb)
	);

	initial begin
		BG_clk = 1'b0;
		forever #4 BG_clk = ~BG_clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic int rand_below(input int n);
		return int'($urandom % n);
	endfunction

	task automatic check_idle_outputs(input string when);
		assert (hsync && vsync && !de && rgb == `NO_COLOUR) else
			report_failure($sformatf("Error at %0t ns: outputs not idle %s", $time, when));
	endtask

	task automatic wait_visible_end();
		int target;
		int cycles;
		target = visible_done + 1;
		cycles = 0;
		while (visible_done < target) begin
			@(posedge BG_clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				report_failure("Timeout waiting for the end of the visible rows");
			end
		end
	endtask

	// Finish the last visible line, so inputs change in blanking line 480
	task automatic wait_blank_line();
		wait_visible_end();
		repeat (`H_TOTAL - `DISP_W) @(negedge BG_clk);
	endtask

	task automatic next_frame(input game_state_t st, input int fr, input int bx, input int by,
		input int px0, input int py0, input int px1, input int py1);
		wait_blank_line();
		game_state  = st;
		bird_frame  = bird_frame_t'(fr);
		bird_x      = coord_t'(bx);
		bird_y      = coord_t'(by);
		pipe_x_flat = {coord_t'(px1), coord_t'(px0)};
		pipe_y_flat = {coord_t'(py1), coord_t'(py0)};
	endtask

	task automatic next_state(input game_state_t st);
		wait_blank_line();
		game_state = st;
	endtask

	task automatic random_frame(input game_state_t st, input int fr);
		int bx;
		int by;
		int px0;
		int px1;
		bx  = rand_below(`DISP_W - `BIRD_W);
		by  = rand_below(`DISP_H - `BIRD_H);
		px0 = rand_below(`DISP_W - 20);
		px1 = rand_below(`DISP_W - 20);
		next_frame(st, fr, bx, by, px0, 60 + rand_below(300), px1, 60 + rand_below(300));
	endtask

	////////////////////////////////////////
	// Stimulus

	initial begin
		void'($urandom(32'hbd65_6677));
		rst         = 1'b1;
		game_state  = start_screen;
		bird_frame  = 2'd0;
		bird_x      = coord_t'(100);
		bird_y      = coord_t'(200);
		pipe_x_flat = {coord_t'(400), coord_t'(200)};
		pipe_y_flat = {coord_t'(300), coord_t'(200)};
		repeat (5) begin
			@(negedge BG_clk);
			check_idle_outputs("during reset");
		end
		rst = 1'b0;
		@(negedge BG_clk);
		check_idle_outputs("after reset");

		// Title screen, pipes in view but never drawn
		next_frame(start_screen, 1, 120, 210, 200, 200, 400, 300);
		// Overlapping pipes, bird across the top of the lower part of pipe 0
		next_frame(in_game, 2, 250, 250, 240, 200, 260, 150);
		// Pipe 0 runs down into the floor, pipe 1 past the right edge
		next_frame(in_game, 0, 60, 80, 100, 100, 610, 260);
		for (int i = 0; i < 4; i++) begin
			random_frame(in_game, i);
		end
		next_state(paused);
		next_state(paused);
		next_state(end_screen);
		random_frame(in_game, 1);
		wait_visible_end();
		$display("test passed");
		$finish;
	end

	////////////////////////////////////////
	// Monitor and compare

	always @(negedge BG_clk) begin
		if (rst) begin
			col            = 0;
			row            = 0;
			hs_low         = 0;
			hs_period      = 0;
			vs_low         = 0;
			frame_cycles   = 0;
			frames_started = 0;
			visible_done   = 0;
			model_hill     = 0;
			model_floor    = 0;
			de_prev        = 1'b0;
			hs_prev        = 1'b1;
			vs_prev        = 1'b1;
			hs_seen        = 1'b0;
			vs_seen        = 1'b0;
		end else begin
			if (de) begin
				// First pixel of a frame, the offsets moved at the last frame start
				if (!de_prev && row == 0) begin
					if (frames_started > 0 && scroll_moves(game_state)) begin
						model_hill  = (model_hill + 1) % `DISP_W;
						model_floor = (model_floor + 2) % `DISP_W;
					end
					frames_started++;
				end
				exp_rgb = expected_rgb(game_state, col, row, model_hill, model_floor,
					int'(bird_x), int'(bird_y), int'(bird_frame), pipe_x_flat, pipe_y_flat);
				assert (rgb == exp_rgb) else
					report_failure($sformatf("Error at %0t ns: pixel (%0d,%0d) is %06h, expected %06h",
						$time, col, row, rgb, exp_rgb));
				col++;
			end else begin
				assert (rgb == `NO_COLOUR) else
					report_failure($sformatf("Error at %0t ns: rgb %06h during blanking", $time, rgb));
				if (de_prev) begin
					assert (col == `DISP_W) else
						report_failure($sformatf("Error at %0t ns: line %0d has %0d pixels",
							$time, row, col));
					row++;
					col = 0;
					if (row == `DISP_H) begin
						visible_done++;
					end
				end
			end
			de_prev = de;

			// hsync low width and line period
			hs_period++;
			if (!hsync && hs_prev) begin
				if (hs_seen) begin
					assert (hs_period == `H_TOTAL) else
						report_failure($sformatf("Error at %0t ns: line period %0d", $time, hs_period));
				end
				hs_seen   = 1'b1;
				hs_period = 0;
				hs_low    = 0;
			end
			if (!hsync) begin
				hs_low++;
			end
			if (hsync && !hs_prev) begin
				assert (hs_low == `H_SYNC) else
					report_failure($sformatf("Error at %0t ns: hsync low for %0d cycles", $time, hs_low));
			end
			hs_prev = hsync;

			// vsync low width and frame period, the end of vsync restarts the scan
			frame_cycles++;
			if (!vsync && vs_prev) begin
				assert (row == `DISP_H) else
					report_failure($sformatf("Error at %0t ns: frame has %0d rows", $time, row));
				if (vs_seen) begin
					assert (frame_cycles == `H_TOTAL * `V_TOTAL) else
						report_failure($sformatf("Error at %0t ns: frame period %0d", $time, frame_cycles));
				end
				vs_seen      = 1'b1;
				frame_cycles = 0;
				vs_low       = 0;
			end
			if (!vsync) begin
				vs_low++;
			end
			if (vsync && !vs_prev) begin
				assert (vs_low == `V_SYNC * `H_TOTAL) else
					report_failure($sformatf("Error at %0t ns: vsync low for %0d cycles", $time, vs_low));
				row = 0;
				col = 0;
			end
			vs_prev = vsync;
		end
	end

endmodule

// ==== rtl/game_display_top.sv ====
// Top level of the pixel path
// Timing, scroll, scenery, bird and compositor, plus sync alignment delays
`timescale 1ns/10ps
`include "render_macros.svh"

module game_display_top
	import render_pkg::*;
(
	input  logic                                 BG_clk,
	input  logic                                 rst,
	input  game_state_t                          game_state,
	input  bird_frame_t                          bird_frame,
	input  coord_t                               bird_x,
	input  coord_t                               bird_y,
	input  logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_x_flat,
	input  logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_y_flat,
	output logic                                 hsync,
	output logic                                 vsync,
	output logic                                 de,
	output rgb_t                                 rgb
);

	coord_t x;
	coord_t y;
	coord_t hill_ofs;
	coord_t floor_ofs;
	logic   hsync_raw;
	logic   vsync_raw;
	logic   display_on;
	logic   frame_start;
	logic   display_on_d;
	rgb_t   scene_colour;
	logic   pipe_hit;
	rgb_t   pipe_colour;
	logic   bird_hit;
	rgb_t   bird_colour;

	// Two-stage delays match the layer and compositor registers
	logic [1:0] hsync_pipe;
	logic [1:0] vsync_pipe;
	logic [1:0] de_pipe;

	vga_timing i_vga_timing (
		.BG_clk      (BG_clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.display_on  (display_on),
		.frame_start (frame_start)
	);

	scroll_offset i_scroll_offset (
		.BG_clk      (BG_clk),
		.rst         (rst),
		.frame_start (frame_start),
		.game_state  (game_state),
		.hill_ofs    (hill_ofs),
		.floor_ofs   (floor_ofs)
	);

	scene_layers i_scene_layers (
		.BG_clk       (BG_clk),
		.rst          (rst),
		.x            (x),
		.y            (y),
		.hill_ofs     (hill_ofs),
		.floor_ofs    (floor_ofs),
		.pipe_x_flat  (pipe_x_flat),
		.pipe_y_flat  (pipe_y_flat),
		.scene_colour (scene_colour),
		.pipe_hit     (pipe_hit),
		.pipe_colour  (pipe_colour)
	);

	bird_sprite i_bird_sprite (
		.BG_clk      (BG_clk),
		.rst         (rst),
		.x           (x),
		.y           (y),
		.bird_x      (bird_x),
		.bird_y      (bird_y),
		.bird_frame  (bird_frame),
		.bird_hit    (bird_hit),
		.bird_colour (bird_colour)
	);

	pixel_compositor i_pixel_compositor (
		.BG_clk       (BG_clk),
		.rst          (rst),
		.game_state   (game_state),
		.display_on_d (display_on_d),
		.scene_colour (scene_colour),
		.pipe_hit     (pipe_hit),
		.pipe_colour  (pipe_colour),
		.bird_hit     (bird_hit),
		.bird_colour  (bird_colour),
		.rgb          (rgb)
	);

	////////////////////////////////////////
	// Sync and visible-area alignment

	// Syncs idle high out of reset
	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			hsync_pipe <= 2'b11;
			vsync_pipe <= 2'b11;
			de_pipe    <= 2'b00;
		end else begin
			hsync_pipe <= {hsync_pipe[0], hsync_raw};
			vsync_pipe <= {vsync_pipe[0], vsync_raw};
			de_pipe    <= {de_pipe[0], display_on};
		end
	end

	// First stage lines up with the layer outputs
	assign display_on_d = de_pipe[0];

	assign hsync = hsync_pipe[1];
	assign vsync = vsync_pipe[1];
	assign de    = de_pipe[1];

endmodule

// ==== rtl/pixel_compositor.sv ====
// Layer priority for each game state
// Pause dimming and the registered output colour
`timescale 1ns/10ps
`include "render_macros.svh"

module pixel_compositor
	import render_pkg::*;
(
	input  logic        BG_clk,
	input  logic        rst,
	input  game_state_t game_state,
	input  logic        display_on_d,
	input  rgb_t        scene_colour,
	input  logic        pipe_hit,
	input  rgb_t        pipe_colour,
	input  logic        bird_hit,
	input  rgb_t        bird_colour,
	output rgb_t        rgb
);

	// Each channel shifted right by two places
	function automatic rgb_t dim_colour(input rgb_t c);
		return {2'b00, c[23:18], 2'b00, c[15:10], 2'b00, c[7:2]};
	endfunction

	rgb_t front_colour;
	rgb_t next_rgb;

	////////////////////////////////////////
	// Priority

	always_comb begin
		case (game_state)
			// No pipes on the title screen
			start_screen: begin
				if (bird_hit) begin
					front_colour = bird_colour;
				end else begin
					front_colour = scene_colour;
				end
			end
			default: begin
				if (bird_hit) begin
					front_colour = bird_colour;
				end else if (pipe_hit) begin
					front_colour = pipe_colour;
				end else begin
					front_colour = scene_colour;
				end
			end
		endcase
	end

	always_comb begin
		if (!display_on_d) begin
			next_rgb = `NO_COLOUR;
		end else if (game_state == paused) begin
			next_rgb = dim_colour(front_colour);
		end else begin
			next_rgb = front_colour;
		end
	end

	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			rgb <= `NO_COLOUR;
		end else begin
			rgb <= next_rgb;
		end
	end

	// Blanking stays black at the output
	a_blank_black: assert property (@(posedge BG_clk) disable iff (rst)
		!display_on_d |=> (rgb == `NO_COLOUR));

endmodule

// ==== rtl/bird_sprite.sv ====
// Bird box test with transparent corner squares
// Flap-frame colour select, registered
`timescale 1ns/10ps
`include "render_macros.svh"

module bird_sprite
	import render_pkg::*;
(
	input  logic        BG_clk,
	input  logic        rst,
	input  coord_t      x,
	input  coord_t      y,
	input  coord_t      bird_x,
	input  coord_t      bird_y,
	input  bird_frame_t bird_frame,
	output logic        bird_hit,
	output rgb_t        bird_colour
);

	localparam logic [10:0] BW = 11'(`BIRD_W);
	localparam logic [10:0] BH = 11'(`BIRD_H);
	localparam logic [10:0] BC = 11'(`BIRD_CORNER);

	logic [10:0] x_w;
	logic [10:0] y_w;
	logic [10:0] bx;
	logic [10:0] by;
	logic [10:0] dx;
	logic [10:0] dy;
	logic        in_box;
	logic        corner_col;
	logic        corner_row;
	logic        hit_c;
	rgb_t        colour_c;

	assign x_w = {1'b0, x};
	assign y_w = {1'b0, y};
	assign bx  = {1'b0, bird_x};
	assign by  = {1'b0, bird_y};

	// Offsets inside the box, meaningful only while in_box is set
	assign dx = x_w - bx;
	assign dy = y_w - by;

	assign in_box = (x_w >= bx) && (x_w < bx + BW) && (y_w >= by) && (y_w < by + BH);

	// Corners are where an edge column meets an edge row
	assign corner_col = (dx < BC) || (dx >= BW - BC);
	assign corner_row = (dy < BC) || (dy >= BH - BC);
	assign hit_c      = in_box && !(corner_col && corner_row);

	always_comb begin
		case (bird_frame)
			2'd1:    colour_c = `BIRD_COLOUR_1;
			2'd2:    colour_c = `BIRD_COLOUR_2;
			default: colour_c = `BIRD_COLOUR_0;
		endcase
	end

	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			bird_hit <= 1'b0;
		end else begin
			bird_hit <= hit_c;
		end
	end

	always_ff @(posedge BG_clk) begin
		bird_colour <= colour_c;
	end

endmodule

// ==== rtl/scene_layers.sv ====
// Scenery band colour by row, sky, hills, floor and ground
// Pipe hit test and pipe colour, all outputs registered
`timescale 1ns/10ps
`include "render_macros.svh"

module scene_layers
	import render_pkg::*;
(
	input  logic                                 BG_clk,
	input  logic                                 rst,
	input  coord_t                               x,
	input  coord_t                               y,
	input  coord_t                               hill_ofs,
	input  coord_t                               floor_ofs,
	input  logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_x_flat,
	input  logic [`NUM_PIPES*$bits(coord_t)-1:0] pipe_y_flat,
	output rgb_t                                 scene_colour,
	output logic                                 pipe_hit,
	output rgb_t                                 pipe_colour
);

	localparam int          CW         = $bits(coord_t);
	localparam coord_t      HILL_ROW   = coord_t'(`HILL_Y);
	localparam coord_t      FLOOR_ROW  = coord_t'(`FLOOR_Y);
	localparam coord_t      GROUND_ROW = coord_t'(`FLOOR_Y + `FLOOR_H);
	localparam logic [10:0] HALF_GAP   = 11'(`PIPE_GAP / 2);
	localparam logic [10:0] EDGE_W     = 11'd4;

	// Column position after scrolling, brought back into 0..639
	function automatic coord_t wrap_col(input coord_t pos, input coord_t ofs);
		logic [10:0] sum;
		sum = {1'b0, pos} + {1'b0, ofs};
		if (sum >= 11'(2 * `DISP_W)) begin
			sum = sum - 11'(2 * `DISP_W);
		end else if (sum >= 11'(`DISP_W)) begin
			sum = sum - 11'(`DISP_W);
		end
		return coord_t'(sum);
	endfunction

	logic [10:0]           x_w;
	logic [10:0]           y_w;
	logic [`NUM_PIPES-1:0] pipe_in;
	logic [`NUM_PIPES-1:0] pipe_edge;
	coord_t                hill_col;
	coord_t                floor_col;
	rgb_t                  band_colour;
	logic                  pipe_hit_c;
	rgb_t                  pipe_colour_c;

	assign x_w = {1'b0, x};
	assign y_w = {1'b0, y};

	////////////////////////////////////////
	// Pipes

	for (genvar i = 0; i < `NUM_PIPES; i++) begin : g_pipe
		logic [10:0] px;
		logic [10:0] py;
		logic [10:0] dx;
		logic        in_cols;
		logic        in_rows;

		assign px = {1'b0, pipe_x_flat[i*CW +: CW]};
		assign py = {1'b0, pipe_y_flat[i*CW +: CW]};
		assign dx = x_w - px;

		assign in_cols = (x_w >= px) && (x_w < px + 11'(`PIPE_W));
		// Outside the gap, rows above pipe_y - 60 or from pipe_y + 60 on
		assign in_rows = (y_w + HALF_GAP < py) || (y_w >= py + HALF_GAP);

		// Floor and ground cover the foot of the pipe
		assign pipe_in[i]   = in_cols && in_rows && (y < FLOOR_ROW);
		assign pipe_edge[i] = (dx < EDGE_W) || (dx >= 11'(`PIPE_W) - EDGE_W);
	end

	// Scan from the top index down so pipe 0 wins on overlap
	always_comb begin
		pipe_hit_c    = 1'b0;
		pipe_colour_c = `PIPE_BODY;
		for (int i = `NUM_PIPES - 1; i >= 0; i--) begin
			if (pipe_in[i]) begin
				pipe_hit_c    = 1'b1;
				pipe_colour_c = pipe_edge[i] ? `PIPE_EDGE : `PIPE_BODY;
			end
		end
	end

	////////////////////////////////////////
	// Scenery bands

	assign hill_col  = wrap_col(x, hill_ofs);
	assign floor_col = wrap_col(x, floor_ofs);

	// Hill stripes are 8 columns wide, floor stripes 4
	always_comb begin
		if (y < HILL_ROW) begin
			band_colour = `SKY_COLOUR;
		end else if (y < FLOOR_ROW) begin
			band_colour = hill_col[3] ? `HILL_LIGHT : `HILL_DARK;
		end else if (y < GROUND_ROW) begin
			band_colour = floor_col[2] ? `FLOOR_LIGHT : `FLOOR_DARK;
		end else begin
			band_colour = `GROUND_COLOUR;
		end
	end

	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			pipe_hit <= 1'b0;
		end else begin
			pipe_hit <= pipe_hit_c;
		end
	end

	always_ff @(posedge BG_clk) begin
		scene_colour <= band_colour;
		pipe_colour  <= pipe_colour_c;
	end

endmodule

// ==== rtl/scroll_offset.sv ====
// Hill and floor scroll offsets
// Advanced once per frame, floor at twice the hill speed
`timescale 1ns/10ps
`include "render_macros.svh"

module scroll_offset
	import render_pkg::*;
(
	input  logic        BG_clk,
	input  logic        rst,
	input  logic        frame_start,
	input  game_state_t game_state,
	output coord_t      hill_ofs,
	output coord_t      floor_ofs
);

	localparam logic [10:0] WRAP = 11'(`DISP_W);

	// One spare bit so the sum can pass 640 before the wrap
	logic [10:0] hill_sum;
	logic [10:0] floor_sum;
	logic        moving;

	assign hill_sum  = {1'b0, hill_ofs} + 11'd1;
	assign floor_sum = {1'b0, floor_ofs} + 11'd2;

	// Scenery freezes while paused and on the end screen
	assign moving = (game_state == start_screen) || (game_state == in_game);

	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			hill_ofs  <= '0;
			floor_ofs <= '0;
		end else if (frame_start && moving) begin
			hill_ofs  <= (hill_sum >= WRAP) ? coord_t'(hill_sum - WRAP) : coord_t'(hill_sum);
			floor_ofs <= (floor_sum >= WRAP) ? coord_t'(floor_sum - WRAP) : coord_t'(floor_sum);
		end
	end

endmodule

// ==== rtl/vga_timing.sv ====
// VGA pixel and line counters
// Active-low sync pulses, visible-area level and frame-start strobe
`timescale 1ns/10ps
`include "render_macros.svh"

module vga_timing
	import render_pkg::*;
(
	input  logic   BG_clk,
	input  logic   rst,
	output coord_t x,
	output coord_t y,
	output logic   hsync_raw,
	output logic   vsync_raw,
	output logic   display_on,
	output logic   frame_start
);

	// Sync windows sit after the front porch
	localparam coord_t HS_START = coord_t'(`DISP_W + `H_FRONT);
	localparam coord_t HS_END   = coord_t'(`DISP_W + `H_FRONT + `H_SYNC);
	localparam coord_t VS_START = coord_t'(`DISP_H + `V_FRONT);
	localparam coord_t VS_END   = coord_t'(`DISP_H + `V_FRONT + `V_SYNC);
	localparam coord_t X_LAST   = coord_t'(`H_TOTAL - 1);
	localparam coord_t Y_LAST   = coord_t'(`V_TOTAL - 1);
	localparam coord_t X_VIS    = coord_t'(`DISP_W);
	localparam coord_t Y_VIS    = coord_t'(`DISP_H);

	logic line_end;
	logic frame_end;

	assign line_end  = (x == X_LAST);
	assign frame_end = line_end && (y == Y_LAST);

	always_ff @(posedge BG_clk or posedge rst) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else if (line_end) begin
			x <= '0;
			if (frame_end) begin
				y <= '0;
			end else begin
				y <= y + coord_t'(1);
			end
		end else begin
			x <= x + coord_t'(1);
		end
	end

	assign hsync_raw  = !((x >= HS_START) && (x < HS_END));
	assign vsync_raw  = !((y >= VS_START) && (y < VS_END));
	assign display_on = (x < X_VIS) && (y < Y_VIS);

	// High on the last count of a frame, the next edge wraps to (0,0)
	assign frame_start = frame_end;

	////////////////////////////////////////
	// Checks

	// Counters stay inside the 800 x 525 frame
	a_counter_range: assert property (@(posedge BG_clk) disable iff (rst)
		(x <= X_LAST) && (y <= Y_LAST));

	// Frame origin always follows the strobe, and only the strobe leads to it
	a_frame_origin: assert property (@(posedge BG_clk) disable iff (rst)
		frame_start |=> (x == '0) && (y == '0));

	a_origin_strobed: assert property (@(posedge BG_clk) disable iff (rst)
		!frame_start |=> !((x == '0) && (y == '0)));

endmodule

// ==== rtl/render_pkg.sv ====
// Shared types of the pixel path
// Coordinates, colours, flap frames and the game state
package render_pkg;

	////////////////////////////////////////
	// Vector types

	// Pixel coordinate or counter value
	typedef logic [9:0] coord_t;

	// 8 bits each of red, green and blue, red on top
	typedef logic [23:0] rgb_t;

	// Flap frame 0 to 2, value 3 shows as frame 0
	typedef logic [1:0] bird_frame_t;

	////////////////////////////////////////
	// Top-level game FSM state

	typedef enum logic [1:0] {
		start_screen = 2'd0,
		in_game      = 2'd1,
		paused       = 2'd2,
		end_screen   = 2'd3
	} game_state_t;

endpackage

// ==== rtl/render_macros.svh ====
// Display geometry and VGA 640x480 sync timing
// Scenery, pipe and bird sizes
// 24-bit colour constants
`ifndef RENDER_MACROS_SVH
`define RENDER_MACROS_SVH

// Visible area
`define DISP_W 640
`define DISP_H 480

// Horizontal timing in pixel clocks
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

// Vertical timing in lines
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// Scenery rows, ground begins below the floor strip
`define HILL_Y 300
`define FLOOR_Y 380
`define FLOOR_H 16

// Pipes
`define PIPE_W 52
`define PIPE_GAP 120
`define NUM_PIPES 2

// Bird box and its transparent corner squares
`define BIRD_W 34
`define BIRD_H 24
`define BIRD_CORNER 4

// Scenery colours
`define SKY_COLOUR 24'h70C5CE
`define HILL_DARK 24'h5EA270
`define HILL_LIGHT 24'hC8F0C8
`define FLOOR_DARK 24'h8AC640
`define FLOOR_LIGHT 24'hA8E060
`define GROUND_COLOUR 24'hDED895

// Pipe colours
`define PIPE_BODY 24'h73BF2E
`define PIPE_EDGE 24'h558022

// Bird colours, one per flap frame
`define BIRD_COLOUR_0 24'hF8D820
`define BIRD_COLOUR_1 24'hF8A020
`define BIRD_COLOUR_2 24'hE04020

// RGB off
`define NO_COLOUR 24'h000000

`endif
